// File: dv/rtcClockTb.sv
// Testbench for rtcClockTop with a behavioral RTC chip model; compile with rtcClockTop.f and run
`timescale 1ns/1ps
`default_nettype none

module rtcClockTb import rtcPkg::*;;

	localparam int CYCLE_LIMIT = 6000;  // About eight sweeps, refresh gaps and edits
	localparam int SWEEP_WAIT  = REG_COUNT * (2 * PHASE_CYCLES + 1) + REFRESH_CYCLES + 20;

	logic       CLK;
	logic       reset;
	logic       editMode;
	logic [3:0] pointer;
	logic       up;
	logic       down;
	logic       store;
	logic [7:0] busIn;
	logic [7:0] busOut;
	logic       busDrive;
	logic       chipSelect;
	logic       addressStrobe;
	logic       readStrobe;
	logic       writeStrobe;
	logic       busy;
	logic       sweepDone;
	logic [7:0] year;
	logic [7:0] month;
	logic [7:0] day;
	logic [7:0] hour;
	logic [7:0] minute;
	logic [7:0] second;
	logic [7:0] timerHour;
	logic [7:0] timerMinute;
	logic [7:0] timerSecond;

	logic [7:0]  displays [REG_COUNT];  // Display bytes by chip address
	logic [7:0]  shadow [REG_COUNT];    // Values expected in the register bank
	logic [7:0]  chipMem [REG_COUNT];   // Chip model registers
	int          chipAddress = 0;       // Address latched by the chip model
	logic [31:0] lfsrState = 32'h442a8261;
	int          cycleCount = 0;
	int          testErrors = 0;
	int          monitorErrors = 0;
	logic        holdOff = 1'b0;        // Bus must stay quiet while set

	rtcClockTop rtcClockTop_inst
	(
		.CLK(CLK), .reset(reset), .editMode(editMode), .pointer(pointer),
		.up(up), .down(down), .store(store), .busIn(busIn),
		.busOut(busOut), .busDrive(busDrive), .chipSelect(chipSelect),
		.addressStrobe(addressStrobe), .readStrobe(readStrobe),
		.writeStrobe(writeStrobe), .busy(busy), .sweepDone(sweepDone),
		.year(year), .month(month), .day(day), .hour(hour), .minute(minute),
		.second(second), .timerHour(timerHour), .timerMinute(timerMinute),
		.timerSecond(timerSecond)
	);

	assign displays[REG_YEAR]  = year;
	assign displays[REG_MONTH] = month;
	assign displays[REG_DAY]   = day;
	assign displays[REG_HOUR]  = hour;
	assign displays[REG_MIN]   = minute;
	assign displays[REG_SEC]   = second;
	assign displays[REG_THOUR] = timerHour;
	assign displays[REG_TMIN]  = timerMinute;
	assign displays[REG_TSEC]  = timerSecond;

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;  // 4 ns period
	end

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
			$display("test errors %0d, monitor errors %0d", testErrors, monitorErrors);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and BCD reference

	function automatic int takeBits(input int count);
		int bits;
		bits = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
			bits = (bits << 1) | int'(lfsrState[0]);  // One step per bit
		end
		return bits;
	endfunction

	function automatic int toBinary(input logic [7:0] bcd);
		return int'(bcd[7:4]) * 10 + int'(bcd[3:0]);
	endfunction

	function automatic logic [7:0] toBcd(input int value);
		logic [7:0] bcd;
		bcd[7:4] = 4'(value / 10);
		bcd[3:0] = 4'(value % 10);
		return bcd;
	endfunction

	// Expected field value after one step that wraps at the field limits
	function automatic logic [7:0] bcdStep(input logic [7:0] value, input int field, input bit goUp);
		int current;
		int low;
		int high;
		current = toBinary(value);
		low     = toBinary(regMinimum[field]);
		high    = toBinary(regMaximum[field]);
		if (goUp)
			current = (current == high) ? low : current + 1;
		else
			current = (current == low) ? high : current - 1;
		return toBcd(current);
	endfunction

	function automatic logic [7:0] randomBcd(input int field);
		int low;
		int span;
		low  = toBinary(regMinimum[field]);
		span = toBinary(regMaximum[field]) - low + 1;
		return toBcd(low + takeBits(8) % span);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Chip model and stimulus helpers working on the falling edge

	task automatic tick();
		@(negedge CLK);
		if (addressStrobe)
			chipAddress = int'(busOut);               // Address seen in the address phase
		if (writeStrobe && chipAddress < REG_COUNT)
			chipMem[chipAddress] = busOut;            // Final write cycle leaves the byte
		busIn = (readStrobe && chipAddress < REG_COUNT) ? chipMem[chipAddress] : 8'h00;
	endtask

	task automatic checkByte(input string testName, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected)
		else
		begin
			$display("error %s expected %h actual %h", testName, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkDisplays(input string testName);
		for (int i = 0; i < REG_COUNT; i++)
			checkByte(testName, shadow[i], displays[i]);
	endtask

	task automatic checkModel(input string testName);
		for (int i = 0; i < REG_COUNT; i++)
			checkByte(testName, shadow[i], chipMem[i]);
	endtask

	task automatic waitSweepDone(input string testName);
		int waited;
		waited = 0;
		tick();
		while (!sweepDone && waited < SWEEP_WAIT)
		begin
			tick();
			waited++;
		end
		assert (sweepDone)
		else
		begin
			$display("%s: no sweepDone pulse within %0d cycles", testName, SWEEP_WAIT);
			testErrors++;
		end
	endtask

	// One cycle of up and down on a field, then compare every display byte
	task automatic editStep(input int field, input bit pressUp, input bit pressDown);
		pointer = 4'(field);
		up      = pressUp;
		down    = pressDown;
		if (field < REG_COUNT && pressUp != pressDown)
			shadow[field] = bcdStep(shadow[field], field, pressUp);
		tick();
		up   = 1'b0;
		down = 1'b0;
		checkDisplays("edit");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus monitor

	int   addressCount = 0;
	logic lastAddressStrobe = 1'b0;

	always @(negedge CLK)
	begin
		if (reset)
			addressCount = 0;
		else
		begin
			if (addressStrobe)
			begin
				if (!lastAddressStrobe)
					addressCount++;                      // New bus cycle
				assert (busOut == 8'(addressCount - 1))  // Addresses 0 to 8 in order
				else
				begin
					$display("error addressOrder expected %h actual %h",
						8'(addressCount - 1), busOut);
					monitorErrors++;
				end
			end
			if (addressStrobe || readStrobe || writeStrobe)
			begin
				assert (chipSelect)                      // Chip selected through both phases
				else
				begin
					$display("error chipSelect expected 1 actual %b", chipSelect);
					monitorErrors++;
				end
			end
			assert (busDrive == (addressStrobe || writeStrobe))  // Chip owns the bus in reads
			else
			begin
				$display("error busDrive expected %b actual %b",
					addressStrobe || writeStrobe, busDrive);
				monitorErrors++;
			end
			if (sweepDone)
			begin
				assert (addressCount == REG_COUNT)
				else
				begin
					$display("sweep ended after %0d bus cycles instead of %0d", addressCount, REG_COUNT);
					monitorErrors++;
				end
				addressCount = 0;
			end
			assert (!(holdOff && chipSelect))
			else
			begin
				$display("chipSelect rose while edit mode held off refresh");
				monitorErrors++;
			end
		end
		lastAddressStrobe = addressStrobe;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial
	begin
		int kind;
		int field;
		int holdStart;
		reset    = 1'b1;
		editMode = 1'b0;
		pointer  = 4'h0;
		up       = 1'b0;
		down     = 1'b0;
		store    = 1'b0;
		busIn    = 8'h00;
		for (int i = 0; i < REG_COUNT; i++)
		begin
			shadow[i]  = randomBcd(i);              // Legal chip contents
			chipMem[i] = shadow[i];
		end
		repeat (5)
			tick();
		checkByte("reset", 8'h00, {1'b0, chipSelect, addressStrobe, readStrobe, writeStrobe,
			busDrive, busy, sweepDone});
		for (int i = 0; i < REG_COUNT; i++)
			checkByte("reset", regMinimum[i], displays[i]);
		reset = 1'b0;

		waitSweepDone("refreshRead");               // First read starts at once
		checkDisplays("refreshRead");

		editMode  = 1'b1;
		holdOff   = 1'b1;
		holdStart = cycleCount;
		repeat (13)
			editStep(REG_MONTH, 1'b1, 1'b0);         // Wraps past 12
		repeat (25)
			editStep(REG_HOUR, 1'b0, 1'b1);          // Wraps below 00
		repeat (2)
			editStep(REG_YEAR, 1'b1, 1'b1);          // Both at once change nothing
		repeat (60)
		begin
			field = takeBits(4);                     // Codes above 8 pick no field
			kind  = takeBits(2);
			editStep(field, kind != 1, kind == 1 || kind == 2);
		end
		while (cycleCount - holdStart < REFRESH_CYCLES + 40)
			tick();
		holdOff = 1'b0;

		store = 1'b1;
		tick();
		store = 1'b0;
		repeat (20)
			tick();
		assert (busy)
		else
		begin
			$display("second store was not given during a sweep");
			testErrors++;
		end
		store = 1'b1;                               // Held pending until the sweep ends
		tick();
		store = 1'b0;
		waitSweepDone("writeBack");
		checkModel("writeBack");
		for (int i = 0; i < REG_COUNT; i++)
			chipMem[i] = ~8'(i);                     // Overwritten only by another write
		waitSweepDone("pendingStore");
		checkModel("pendingStore");

		editMode = 1'b0;                            // Refresh already due
		waitSweepDone("readAfterWrite");
		checkDisplays("readAfterWrite");

		$display("test errors %0d, monitor errors %0d", testErrors, monitorErrors);
		if (testErrors + monitorErrors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/bcdEditRegister.sv
// One BCD byte of the register bank, loaded from the bus or stepped up and down within its limits
`timescale 1ns/1ps
`default_nettype none

module bcdEditRegister
#(
	parameter logic [7:0] minimum = 8'h00,  // Lowest legal BCD value
	parameter logic [7:0] maximum = 8'h99   // Highest legal BCD value
)
(
	input  logic       CLK,
	input  logic       reset,
	input  logic       load,        // Take the bus byte
	input  logic [7:0] loadData,
	input  logic       editSelect,  // Pointer sits on this field
	input  logic       up,
	input  logic       down,
	output logic [7:0] value
);

	logic [7:0] stepUp;    // Next value going up
	logic [7:0] stepDown;  // Next value going down

	always_comb
	begin
		if (value == maximum)
			stepUp = minimum;                        // Wrap to bottom
		else if (value[3:0] == 4'h9)
			stepUp = {value[7:4] + 4'h1, 4'h0};     // Carry into tens
		else
			stepUp = {value[7:4], value[3:0] + 4'h1};

		if (value == minimum)
			stepDown = maximum;                      // Wrap to top
		else if (value[3:0] == 4'h0)
			stepDown = {value[7:4] - 4'h1, 4'h9};   // Borrow from tens
		else
			stepDown = {value[7:4], value[3:0] - 4'h1};
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			value <= minimum;
		else if (load)
			value <= loadData;                       // Bus load beats an edit
		else if (editSelect && up && !down)
			value <= stepUp;
		else if (editSelect && down && !up)
			value <= stepDown;
	end

endmodule

`default_nettype wire

// File: logic/rtcBusSequencer.sv
// FSM that walks the nine chip registers through address and data phases in read or write sweeps
`timescale 1ns/1ps
`default_nettype none

module rtcBusSequencer import rtcPkg::*;
(
	input  logic          CLK,
	input  logic          reset,
	input  logic          editMode,       // Operator editing holds off reads
	input  logic          store,          // Request to write the bank back
	input  logic          phaseDone,
	input  logic          refreshDue,
	output logic          phaseRun,
	output logic          sweepStart,
	output busOp_t        sweepOp,        // Kind chosen for the sweep that starts
	output logic          busy,
	output logic          sweepDone,
	output logic          chipSelect,
	output logic          addressStrobe,
	output logic          readStrobe,
	output logic          writeStrobe,
	rtcStrobeIf.sequencer bus
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_ADDRESS,
		ST_DATA,
		ST_RECOVER   // One quiet cycle between bus cycles
	} seqState_t;

	seqState_t  state;
	logic [3:0] index;         // Register being transferred
	busOp_t     op;            // Kind of the running sweep
	logic       storePending;  // Store seen during a sweep
	logic       writeRequest;
	logic       readRequest;
	logic       lastIndex;

	assign writeRequest = storePending || store;
	assign readRequest  = refreshDue && !editMode;      // No reads over edits
	assign sweepStart   = (state == ST_IDLE) && (writeRequest || readRequest);
	assign sweepOp      = writeRequest ? OP_WRITE : OP_READ;  // Write wins
	assign lastIndex    = (index == 4'(REG_COUNT - 1));

	////////////////////////////////////////////////////////////////////////////
	// State machine

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state        <= ST_IDLE;
			index        <= '0;
			op           <= OP_READ;
			storePending <= 1'b0;
			sweepDone    <= 1'b0;
		end
		else
		begin
			sweepDone <= 1'b0;

			if (sweepStart && sweepOp == OP_WRITE)
				storePending <= 1'b0;                   // Request taken
			else if (store)
				storePending <= 1'b1;

			case (state)
				ST_IDLE:
					if (sweepStart)
					begin
						state <= ST_ADDRESS;
						index <= '0;
						op    <= sweepOp;
					end
				ST_ADDRESS:
					if (phaseDone)
						state <= ST_DATA;
				ST_DATA:
					if (phaseDone)
						state <= ST_RECOVER;
				ST_RECOVER:
					if (lastIndex)
					begin
						state     <= ST_IDLE;
						sweepDone <= 1'b1;              // Pulse after last quiet cycle
					end
					else
					begin
						state <= ST_ADDRESS;
						index <= index + 4'd1;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobes decoded from state

	assign phaseRun      = (state == ST_ADDRESS) || (state == ST_DATA);
	assign busy          = (state != ST_IDLE);
	assign chipSelect    = phaseRun;                    // Address plus data phase
	assign addressStrobe = (state == ST_ADDRESS);
	assign readStrobe    = (state == ST_DATA) && (op == OP_READ);
	assign writeStrobe   = (state == ST_DATA) && (op == OP_WRITE);

	assign bus.sendAddress = addressStrobe;
	assign bus.sendData    = writeStrobe;
	assign bus.receiveData = readStrobe && phaseDone;   // Sample at end of read phase
	assign bus.address     = {4'h0, index};
	assign bus.op          = op;

endmodule

`default_nettype wire

// File: logic/rtcClockTop.sv
// Top level of the RTC front end with split bus pins and the nine BCD display bytes as plain ports
`timescale 1ns/1ps
`default_nettype none

module rtcClockTop import rtcPkg::*;
(
	input  logic       CLK,
	input  logic       reset,
	input  logic       editMode,
	input  logic [3:0] pointer,
	input  logic       up,
	input  logic       down,
	input  logic       store,
	input  logic [7:0] busIn,
	output logic [7:0] busOut,
	output logic       busDrive,
	output logic       chipSelect,
	output logic       addressStrobe,
	output logic       readStrobe,
	output logic       writeStrobe,
	output logic       busy,
	output logic       sweepDone,
	output logic [7:0] year,
	output logic [7:0] month,
	output logic [7:0] day,
	output logic [7:0] hour,
	output logic [7:0] minute,
	output logic [7:0] second,
	output logic [7:0] timerHour,
	output logic [7:0] timerMinute,
	output logic [7:0] timerSecond
);

	logic                      phaseRun;
	logic                      phaseDone;
	logic                      refreshDue;
	logic                      sweepStart;
	busOp_t                    sweepOp;
	logic [REG_COUNT-1:0][7:0] regValues;

	rtcStrobeIf strobes ();  // Sequencer to multiplexer

	rtcBusSequencer rtcBusSequencer_inst
	(
		.CLK(CLK),
		.reset(reset),
		.editMode(editMode),
		.store(store),
		.phaseDone(phaseDone),
		.refreshDue(refreshDue),
		.phaseRun(phaseRun),
		.sweepStart(sweepStart),
		.sweepOp(sweepOp),
		.busy(busy),
		.sweepDone(sweepDone),
		.chipSelect(chipSelect),
		.addressStrobe(addressStrobe),
		.readStrobe(readStrobe),
		.writeStrobe(writeStrobe),
		.bus(strobes.sequencer)
	);

	rtcPhaseTimer rtcPhaseTimer_inst
	(
		.CLK(CLK),
		.reset(reset),
		.phaseRun(phaseRun),
		.sweepStart(sweepStart),
		.sweepOp(sweepOp),
		.sweepDone(sweepDone),
		.phaseDone(phaseDone),
		.refreshDue(refreshDue)
	);

	rtcMultiplexer rtcMultiplexer_inst
	(
		.CLK(CLK),
		.reset(reset),
		.pointer(pointer),
		.editMode(editMode),
		.up(up),
		.down(down),
		.busIn(busIn),
		.bus(strobes.multiplexer),
		.busOut(busOut),
		.busDrive(busDrive),
		.regValues(regValues)
	);

	// Display bytes by chip address
	assign year        = regValues[REG_YEAR];
	assign month       = regValues[REG_MONTH];
	assign day         = regValues[REG_DAY];
	assign hour        = regValues[REG_HOUR];
	assign minute      = regValues[REG_MIN];
	assign second      = regValues[REG_SEC];
	assign timerHour   = regValues[REG_THOUR];
	assign timerMinute = regValues[REG_TMIN];
	assign timerSecond = regValues[REG_TSEC];

endmodule

`default_nettype wire

// File: logic/rtcMultiplexer.sv
// Bus multiplexer that latches the chip address, loads or edits the BCD register bank and drives bus data
`timescale 1ns/1ps
`default_nettype none

module rtcMultiplexer import rtcPkg::*;
(
	input  logic                       CLK,
	input  logic                       reset,
	input  logic [3:0]                 pointer,    // Field under edit
	input  logic                       editMode,
	input  logic                       up,
	input  logic                       down,
	input  logic [7:0]                 busIn,      // Data from the chip
	rtcStrobeIf.multiplexer            bus,
	output logic [7:0]                 busOut,
	output logic                       busDrive,   // Our side owns the bus
	output logic [REG_COUNT-1:0][7:0]  regValues   // Display bytes by address
);

	logic [7:0]           latchedAddress;  // Address of the current bus cycle
	logic [REG_COUNT-1:0] loadSelect;      // One-hot bus load enables
	logic [REG_COUNT-1:0] editSelect;      // One-hot edit enables
	logic [7:0]           dataOut;         // Byte offered in a write phase

	always_ff @(posedge CLK)
	begin
		if (reset)
			latchedAddress <= '0;
		else if (bus.sendAddress)
			latchedAddress <= bus.address;          // Follows the address phase
	end

	////////////////////////////////////////////////////////////////////////////
	// Load and edit decode

	always_comb
	begin
		for (int i = 0; i < REG_COUNT; i++)
		begin
			loadSelect[i] = bus.receiveData && (bus.op == OP_READ)
				&& (latchedAddress == 8'(i));
			editSelect[i] = editMode && (pointer == 4'(i));  // Pointer codes above 8 pick none
		end
	end

	for (genvar i = 0; i < REG_COUNT; i++)
	begin : regBank
		bcdEditRegister
		#(
			.minimum(regMinimum[i]),
			.maximum(regMaximum[i])
		)
		fieldReg
		(
			.CLK(CLK),
			.reset(reset),
			.load(loadSelect[i]),
			.loadData(busIn),
			.editSelect(editSelect[i]),
			.up(up),
			.down(down),
			.value(regValues[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Write data select and bus drive

	always_comb
	begin
		dataOut = 8'hFF;                            // Unmapped addresses
		for (int i = 0; i < REG_COUNT; i++)
			if (latchedAddress == 8'(i))
				dataOut = regValues[i];
	end

	assign busOut   = bus.sendAddress ? bus.address : dataOut;
	assign busDrive = bus.sendAddress || bus.sendData;

endmodule

`default_nettype wire

// File: logic/rtcPhaseTimer.sv
// Phase length counter and refresh interval counter that pace the bus sequencer
`timescale 1ns/1ps
`default_nettype none

module rtcPhaseTimer import rtcPkg::*;
(
	input  logic   CLK,
	input  logic   reset,
	input  logic   phaseRun,    // Sequencer is in an address or data phase
	input  logic   sweepStart,  // New sweep begins this cycle
	input  busOp_t sweepOp,     // Kind of the sweep that begins
	input  logic   sweepDone,   // Previous sweep finished
	output logic   phaseDone,   // Last cycle of the current phase
	output logic   refreshDue   // Read sweep wanted
);

	logic [PHASE_W-1:0]   phaseCount;
	logic [REFRESH_W-1:0] refreshCount;
	logic                 refreshRun;     // Interval being measured
	logic                 refreshExpire;  // Interval ends this cycle

	assign phaseDone     = phaseRun && (phaseCount == PHASE_W'(PHASE_CYCLES - 1));
	assign refreshExpire = refreshRun && (refreshCount == REFRESH_W'(REFRESH_CYCLES - 1));

	always_ff @(posedge CLK)
	begin
		if (reset || !phaseRun || phaseDone)
			phaseCount <= '0;                           // Restart for each phase
		else
			phaseCount <= phaseCount + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Refresh interval

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			refreshRun   <= 1'b0;
			refreshCount <= '0;
			refreshDue   <= 1'b1;                       // First read right after reset
		end
		else
		begin
			if (sweepDone)
			begin
				refreshRun   <= 1'b1;                   // Gap starts at sweep end
				refreshCount <= '0;
			end
			else if (refreshRun)
			begin
				refreshRun   <= !refreshExpire;
				refreshCount <= refreshCount + 1'b1;
			end

			if (refreshExpire)
				refreshDue <= 1'b1;
			else if (sweepStart && sweepOp == OP_READ)
				refreshDue <= 1'b0;                     // Served by this read sweep
		end
	end

endmodule

`default_nettype wire

// File: logic/rtcPkg.sv
// Shared register map, BCD field limits and bus timing for the RTC front end; import with rtcPkg::*
`default_nettype none

package rtcPkg;

	////////////////////////////////////////////////////////////////////////////
	// Register map whose chip addresses double as edit pointer codes

	localparam int REG_COUNT = 9;  // Clock and timer registers on the chip

	localparam int REG_YEAR  = 0;
	localparam int REG_MONTH = 1;
	localparam int REG_DAY   = 2;
	localparam int REG_HOUR  = 3;
	localparam int REG_MIN   = 4;
	localparam int REG_SEC   = 5;
	localparam int REG_THOUR = 6;  // Timer hours
	localparam int REG_TMIN  = 7;  // Timer minutes
	localparam int REG_TSEC  = 8;  // Timer seconds

	// BCD wrap limits per field indexed by register address
	localparam logic [7:0] regMinimum [REG_COUNT] =
		'{8'h00, 8'h01, 8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
	localparam logic [7:0] regMaximum [REG_COUNT] =
		'{8'h99, 8'h12, 8'h31, 8'h23, 8'h59, 8'h59, 8'h23, 8'h59, 8'h59};

	////////////////////////////////////////////////////////////////////////////
	// Bus timing

	localparam int PHASE_CYCLES   = 4;    // Cycles per address or data phase
	localparam int PHASE_W        = $clog2(PHASE_CYCLES);
	localparam int REFRESH_CYCLES = 200;  // Gap from sweep end to next read sweep
	localparam int REFRESH_W      = $clog2(REFRESH_CYCLES);

	typedef enum logic
	{
		OP_READ,   // Chip to register bank
		OP_WRITE   // Register bank to chip
	} busOp_t;

endpackage

`default_nettype wire

// File: logic/rtcStrobeIf.sv
// Bundle of sequencer strobes and register address, driven by the sequencer, read by the multiplexer
`timescale 1ns/1ps
`default_nettype none

interface rtcStrobeIf import rtcPkg::*; ();

	logic       sendAddress;  // High through the address phase
	logic       receiveData;  // Single pulse, last cycle of a read data phase
	logic       sendData;     // High through a write data phase
	logic [7:0] address;      // Register index of the current bus cycle
	busOp_t     op;           // Kind of sweep in progress

	modport sequencer
	(
		output sendAddress,
		output receiveData,
		output sendData,
		output address,
		output op
	);

	modport multiplexer
	(
		input sendAddress,
		input receiveData,
		input sendData,
		input address,
		input op
	);

endinterface

`default_nettype wire

// File: rtcClockTop.f
logic/rtcPkg.sv
logic/rtcStrobeIf.sv
logic/bcdEditRegister.sv
logic/rtcPhaseTimer.sv
logic/rtcBusSequencer.sv
logic/rtcMultiplexer.sv
logic/rtcClockTop.sv
dv/rtcClockTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the RTC front end testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rtcClockTb \
	-f rtcClockTop.f --Mdir obj_dir -o rtcClockSim

./obj_dir/rtcClockSim | tee sim.log

if grep -qx "No errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
